// ==== source/isa_pkg.sv ====
package isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_index_t;

  // major opcodes, instruction bits 6 to 2
  localparam logic [4:0] opcode_load   = 5'b00000;
  localparam logic [4:0] opcode_store  = 5'b01000;
  localparam logic [4:0] opcode_branch = 5'b11000;
  localparam logic [4:0] opcode_jal    = 5'b11011;
  localparam logic [4:0] opcode_jalr   = 5'b11001;
  localparam logic [4:0] opcode_lui    = 5'b01101;
  localparam logic [4:0] opcode_auipc  = 5'b00101;
  localparam logic [4:0] opcode_op_imm = 5'b00100;
  localparam logic [4:0] opcode_op     = 5'b01100;
  localparam logic [4:0] opcode_system = 5'b11100;

  // low two bits, 3 marks a full width instruction
  localparam logic [1:0] quadrant_c0   = 2'b00;
  localparam logic [1:0] quadrant_c1   = 2'b01;
  localparam logic [1:0] quadrant_c2   = 2'b10;
  localparam logic [1:0] quadrant_full = 2'b11;

  typedef enum logic [5:0] {
    op_none,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_bltu,
    op_bgeu,
    op_lb,
    op_lh,
    op_lw,
    op_lbu,
    op_lhu,
    op_sb,
    op_sh,
    op_sw,
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_ecall,
    op_ebreak
  } op_e;

  typedef enum logic [3:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j,
    imm_cl,
    imm_clwsp,
    imm_css,
    imm_cj,
    imm_cb,
    imm_cli,
    imm_clui,
    imm_caddi16sp,
    imm_caddi4spn
  } imm_format_e;

  localparam reg_index_t sp_index = 5'd2;
  localparam reg_index_t ra_index = 5'd1;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

  // word as handed over by fetch
  typedef struct packed {
    isa_pkg::word_t instr;
    isa_pkg::word_t pc;
  } fetch_t;

  // per decoder classification, before the immediate is built
  typedef struct packed {
    isa_pkg::op_e        op;
    isa_pkg::imm_format_e imm_format;
    logic                uses_imm;
    isa_pkg::reg_index_t rd;
    isa_pkg::reg_index_t rs1;
    isa_pkg::reg_index_t rs2;
    logic                illegal;
  } class_t;

  typedef struct packed {
    isa_pkg::op_e        op;
    logic                uses_imm;
    isa_pkg::reg_index_t rd;
    isa_pkg::reg_index_t rs1;
    isa_pkg::reg_index_t rs2;
    isa_pkg::word_t      immediate;
    isa_pkg::word_t      pc;
    isa_pkg::word_t      next_pc;
    logic                compressed;
    logic                illegal;
  } decoded_t;

endpackage

// ==== source/rv32i_decoder.sv ====
`timescale 1ns/1ns

module rv32i_decoder (
  input  var isa_pkg::word_t   instr,
  output var pipe_pkg::class_t result
);

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:2];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    result.op         = isa_pkg::op_none;
    result.imm_format = isa_pkg::imm_none;
    result.uses_imm   = 1'b0;
    result.rd         = instr[11:7];
    result.rs1        = instr[19:15];
    result.rs2        = instr[24:20];
    result.illegal    = 1'b0;

    case (opcode)
      isa_pkg::opcode_lui: begin
        result.op         = isa_pkg::op_lui;
        result.imm_format = isa_pkg::imm_u;
        result.uses_imm   = 1'b1;
      end
      isa_pkg::opcode_auipc: begin
        result.op         = isa_pkg::op_auipc;
        result.imm_format = isa_pkg::imm_u;
        result.uses_imm   = 1'b1;
      end
      isa_pkg::opcode_jal: begin
        result.op         = isa_pkg::op_jal;
        result.imm_format = isa_pkg::imm_j;
        result.uses_imm   = 1'b1;
      end
      isa_pkg::opcode_jalr: begin
        result.imm_format = isa_pkg::imm_i;
        result.uses_imm   = 1'b1;
        if (funct3 == 3'b000) result.op = isa_pkg::op_jalr;
        else result.illegal = 1'b1;
      end
      isa_pkg::opcode_branch: begin
        result.imm_format = isa_pkg::imm_b;
        result.rd         = '0;
        case (funct3)
          3'b000:  result.op = isa_pkg::op_beq;
          3'b001:  result.op = isa_pkg::op_bne;
          3'b100:  result.op = isa_pkg::op_blt;
          3'b101:  result.op = isa_pkg::op_bge;
          3'b110:  result.op = isa_pkg::op_bltu;
          3'b111:  result.op = isa_pkg::op_bgeu;
          default: result.illegal = 1'b1;
        endcase
      end
      isa_pkg::opcode_load: begin
        result.imm_format = isa_pkg::imm_i;
        result.uses_imm   = 1'b1;
        case (funct3)
          3'b000:  result.op = isa_pkg::op_lb;
          3'b001:  result.op = isa_pkg::op_lh;
          3'b010:  result.op = isa_pkg::op_lw;
          3'b100:  result.op = isa_pkg::op_lbu;
          3'b101:  result.op = isa_pkg::op_lhu;
          default: result.illegal = 1'b1;
        endcase
      end
      isa_pkg::opcode_store: begin
        result.imm_format = isa_pkg::imm_s;
        result.uses_imm   = 1'b1;
        result.rd         = '0;
        case (funct3)
          3'b000:  result.op = isa_pkg::op_sb;
          3'b001:  result.op = isa_pkg::op_sh;
          3'b010:  result.op = isa_pkg::op_sw;
          default: result.illegal = 1'b1;
        endcase
      end
      // immediate arithmetic shares the register ops
      isa_pkg::opcode_op_imm: begin
        result.imm_format = isa_pkg::imm_i;
        result.uses_imm   = 1'b1;
        case (funct3)
          3'b000: result.op = isa_pkg::op_add;
          3'b010: result.op = isa_pkg::op_slt;
          3'b011: result.op = isa_pkg::op_sltu;
          3'b100: result.op = isa_pkg::op_xor;
          3'b110: result.op = isa_pkg::op_or;
          3'b111: result.op = isa_pkg::op_and;
          3'b001: begin
            if (funct7 == funct7_base) result.op = isa_pkg::op_sll;
            else result.illegal = 1'b1;
          end
          default: begin
            if (funct7 == funct7_base) result.op = isa_pkg::op_srl;
            else if (funct7 == funct7_alt) result.op = isa_pkg::op_sra;
            else result.illegal = 1'b1;
          end
        endcase
      end
      isa_pkg::opcode_op: begin
        if (funct7 == funct7_base) begin
          case (funct3)
            3'b000: result.op = isa_pkg::op_add;
            3'b001: result.op = isa_pkg::op_sll;
            3'b010: result.op = isa_pkg::op_slt;
            3'b011: result.op = isa_pkg::op_sltu;
            3'b100: result.op = isa_pkg::op_xor;
            3'b101: result.op = isa_pkg::op_srl;
            3'b110: result.op = isa_pkg::op_or;
            default: result.op = isa_pkg::op_and;
          endcase
        end else if (funct7 == funct7_alt && funct3 == 3'b000) begin
          result.op = isa_pkg::op_sub;
        end else if (funct7 == funct7_alt && funct3 == 3'b101) begin
          result.op = isa_pkg::op_sra;
        end else begin
          result.illegal = 1'b1;
        end
      end
      // only ecall and ebreak, everything else is csr space
      isa_pkg::opcode_system: begin
        if (funct3 != 3'b000 || instr[19:15] != '0 || instr[11:7] != '0) result.illegal = 1'b1;
        else if (instr[31:20] == 12'd0) result.op = isa_pkg::op_ecall;
        else if (instr[31:20] == 12'd1) result.op = isa_pkg::op_ebreak;
        else result.illegal = 1'b1;
      end
      default: result.illegal = 1'b1;
    endcase
  end

endmodule

// ==== source/rvc_decoder.sv ====
`timescale 1ns/1ns

module rvc_decoder (
  input  var isa_pkg::word_t   instr,
  output var pipe_pkg::class_t result
);

  logic [1:0] quadrant;
  logic [2:0] funct3;
  isa_pkg::reg_index_t rd_full;
  isa_pkg::reg_index_t rs2_full;
  // compact register fields map to x8..x15
  isa_pkg::reg_index_t rd_p;
  isa_pkg::reg_index_t rs1_p;
  logic imm6_zero;

  assign quadrant  = instr[1:0];
  assign funct3    = instr[15:13];
  assign rd_full   = instr[11:7];
  assign rs2_full  = instr[6:2];
  assign rd_p      = {2'b01, instr[4:2]};
  assign rs1_p     = {2'b01, instr[9:7]};
  assign imm6_zero = {instr[12], instr[6:2]} == 6'd0;

  always_comb begin
    result.op         = isa_pkg::op_none;
    result.imm_format = isa_pkg::imm_none;
    result.uses_imm   = 1'b1;
    result.rd         = '0;
    result.rs1        = '0;
    result.rs2        = '0;
    result.illegal    = 1'b0;

    case ({quadrant, funct3})
      {isa_pkg::quadrant_c0, 3'b000}: begin
        result.op         = isa_pkg::op_add;
        result.imm_format = isa_pkg::imm_caddi4spn;
        result.rd         = rd_p;
        result.rs1        = isa_pkg::sp_index;
        // also catches the all-zero word
        result.illegal    = instr[12:5] == 8'd0;
      end
      {isa_pkg::quadrant_c0, 3'b010}: begin
        result.op         = isa_pkg::op_lw;
        result.imm_format = isa_pkg::imm_cl;
        result.rd         = rd_p;
        result.rs1        = rs1_p;
      end
      {isa_pkg::quadrant_c0, 3'b110}: begin
        result.op         = isa_pkg::op_sw;
        result.imm_format = isa_pkg::imm_cl;
        result.rs1        = rs1_p;
        result.rs2        = rd_p;
      end
      {isa_pkg::quadrant_c1, 3'b000}: begin
        result.op         = isa_pkg::op_add;
        result.imm_format = isa_pkg::imm_cli;
        result.rd         = rd_full;
        result.rs1        = rd_full;
      end
      {isa_pkg::quadrant_c1, 3'b001}, {isa_pkg::quadrant_c1, 3'b101}: begin
        result.op         = isa_pkg::op_jal;
        result.imm_format = isa_pkg::imm_cj;
        // c.jal links, c.j does not
        result.rd         = funct3[2] ? 5'd0 : isa_pkg::ra_index;
      end
      {isa_pkg::quadrant_c1, 3'b010}: begin
        result.op         = isa_pkg::op_add;
        result.imm_format = isa_pkg::imm_cli;
        result.rd         = rd_full;
      end
      {isa_pkg::quadrant_c1, 3'b011}: begin
        result.illegal = imm6_zero;
        if (rd_full == isa_pkg::sp_index) begin
          result.op         = isa_pkg::op_add;
          result.imm_format = isa_pkg::imm_caddi16sp;
          result.rd         = isa_pkg::sp_index;
          result.rs1        = isa_pkg::sp_index;
        end else begin
          result.op         = isa_pkg::op_lui;
          result.imm_format = isa_pkg::imm_clui;
          result.rd         = rd_full;
        end
      end
      {isa_pkg::quadrant_c1, 3'b100}: begin
        result.imm_format = isa_pkg::imm_cli;
        result.rd         = rs1_p;
        result.rs1        = rs1_p;
        // shamt[5] is reserved on rv32
        result.illegal    = instr[12] && instr[11:10] != 2'b10;
        case (instr[11:10])
          2'b00: result.op = isa_pkg::op_srl;
          2'b01: result.op = isa_pkg::op_sra;
          2'b10: result.op = isa_pkg::op_and;
          default: begin
            result.imm_format = isa_pkg::imm_none;
            result.uses_imm   = 1'b0;
            result.rs2        = rd_p;
            case (instr[6:5])
              2'b00:   result.op = isa_pkg::op_sub;
              2'b01:   result.op = isa_pkg::op_xor;
              2'b10:   result.op = isa_pkg::op_or;
              default: result.op = isa_pkg::op_and;
            endcase
          end
        endcase
      end
      {isa_pkg::quadrant_c1, 3'b110}, {isa_pkg::quadrant_c1, 3'b111}: begin
        result.op         = funct3[0] ? isa_pkg::op_bne : isa_pkg::op_beq;
        result.imm_format = isa_pkg::imm_cb;
        result.uses_imm   = 1'b0;
        result.rs1        = rs1_p;
      end
      {isa_pkg::quadrant_c2, 3'b000}: begin
        result.op         = isa_pkg::op_sll;
        result.imm_format = isa_pkg::imm_cli;
        result.rd         = rd_full;
        result.rs1        = rd_full;
        result.illegal    = instr[12];
      end
      {isa_pkg::quadrant_c2, 3'b010}: begin
        result.op         = isa_pkg::op_lw;
        result.imm_format = isa_pkg::imm_clwsp;
        result.rd         = rd_full;
        result.rs1        = isa_pkg::sp_index;
        result.illegal    = rd_full == 5'd0;
      end
      {isa_pkg::quadrant_c2, 3'b100}: begin
        if (rs2_full != 5'd0) begin
          // c.mv and c.add
          result.op       = isa_pkg::op_add;
          result.uses_imm = 1'b0;
          result.rd       = rd_full;
          result.rs1      = instr[12] ? rd_full : 5'd0;
          result.rs2      = rs2_full;
        end else if (instr[12] && rd_full == 5'd0) begin
          result.op       = isa_pkg::op_ebreak;
          result.uses_imm = 1'b0;
        end else begin
          result.op      = isa_pkg::op_jalr;
          result.rd      = instr[12] ? isa_pkg::ra_index : 5'd0;
          result.rs1     = rd_full;
          result.illegal = rd_full == 5'd0;
        end
      end
      {isa_pkg::quadrant_c2, 3'b110}: begin
        result.op         = isa_pkg::op_sw;
        result.imm_format = isa_pkg::imm_css;
        result.rs1        = isa_pkg::sp_index;
        result.rs2        = rs2_full;
      end
      default: result.illegal = 1'b1;
    endcase

    if (result.illegal) result.op = isa_pkg::op_none;
  end

endmodule

// ==== source/immediate_gen.sv ====
`timescale 1ns/1ns

module immediate_gen (
  input  var isa_pkg::word_t      instr,
  input  var isa_pkg::imm_format_e imm_format,
  output var isa_pkg::word_t      immediate
);

  isa_pkg::word_t i_imm, s_imm, b_imm, u_imm, j_imm;
  isa_pkg::word_t cl_imm, clwsp_imm, css_imm, cj_imm, cb_imm;
  isa_pkg::word_t cli_imm, clui_imm, caddi16sp_imm, caddi4spn_imm;

  // base formats
  assign i_imm = {{20{instr[31]}}, instr[31:20]};
  assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign u_imm = {instr[31:12], 12'b0};
  assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // compressed, offsets scaled by the access size
  assign cl_imm    = {25'b0, instr[5], instr[12:10], instr[6], 2'b00};
  assign clwsp_imm = {24'b0, instr[3:2], instr[12], instr[6:4], 2'b00};
  assign css_imm   = {24'b0, instr[8:7], instr[12:9], 2'b00};
  assign cj_imm    = {{21{instr[12]}}, instr[8], instr[10:9], instr[6], instr[7], instr[2],
                      instr[11], instr[5:3], 1'b0};
  assign cb_imm    = {{24{instr[12]}}, instr[6:5], instr[2], instr[11:10], instr[4:3], 1'b0};
  assign cli_imm   = {{27{instr[12]}}, instr[6:2]};
  assign clui_imm  = {{15{instr[12]}}, instr[6:2], 12'b0};
  assign caddi16sp_imm = {{23{instr[12]}}, instr[4:3], instr[5], instr[2], instr[6], 4'b0};
  assign caddi4spn_imm = {22'b0, instr[10:7], instr[12:11], instr[5], instr[6], 2'b00};

  always_comb begin
    case (imm_format)
      isa_pkg::imm_i:         immediate = i_imm;
      isa_pkg::imm_s:         immediate = s_imm;
      isa_pkg::imm_b:         immediate = b_imm;
      isa_pkg::imm_u:         immediate = u_imm;
      isa_pkg::imm_j:         immediate = j_imm;
      isa_pkg::imm_cl:        immediate = cl_imm;
      isa_pkg::imm_clwsp:     immediate = clwsp_imm;
      isa_pkg::imm_css:       immediate = css_imm;
      isa_pkg::imm_cj:        immediate = cj_imm;
      isa_pkg::imm_cb:        immediate = cb_imm;
      isa_pkg::imm_cli:       immediate = cli_imm;
      isa_pkg::imm_clui:      immediate = clui_imm;
      isa_pkg::imm_caddi16sp: immediate = caddi16sp_imm;
      isa_pkg::imm_caddi4spn: immediate = caddi4spn_imm;
      default:                immediate = '0;
    endcase
  end

endmodule

// ==== source/decode_logic.sv ====
`timescale 1ns/1ns

module decode_logic (
  input  var pipe_pkg::fetch_t   fetch,
  output var pipe_pkg::decoded_t next
);

  pipe_pkg::class_t base_class;
  pipe_pkg::class_t comp_class;
  pipe_pkg::class_t sel_class;
  isa_pkg::word_t   immediate;
  logic             compressed;

  assign compressed = fetch.instr[1:0] != isa_pkg::quadrant_full;

  rv32i_decoder u_rv32i_decoder (
    .instr  (fetch.instr),
    .result (base_class)
  );

  rvc_decoder u_rvc_decoder (
    .instr  (fetch.instr),
    .result (comp_class)
  );

  assign sel_class = compressed ? comp_class : base_class;

  immediate_gen u_immediate_gen (
    .instr      (fetch.instr),
    .imm_format (sel_class.imm_format),
    .immediate  (immediate)
  );

  always_comb begin
    next.op         = sel_class.op;
    next.uses_imm   = sel_class.uses_imm;
    next.rd         = sel_class.rd;
    next.rs1        = sel_class.rs1;
    next.rs2        = sel_class.rs2;
    next.immediate  = immediate;
    next.pc         = fetch.pc;
    // sequential pc only, targets are resolved later
    next.next_pc    = fetch.pc + (compressed ? isa_pkg::word_t'(2) : isa_pkg::word_t'(4));
    next.compressed = compressed;
    next.illegal    = sel_class.illegal;
  end

endmodule

// ==== source/stage_register.sv ====
`timescale 1ns/1ns

module stage_register (
  input  var logic               clk,
  input  var logic               reset,
  input  var logic               in_valid,
  output var logic               in_ready,
  input  var pipe_pkg::decoded_t next,
  output var logic               out_valid,
  input  var logic               out_ready,
  output var pipe_pkg::decoded_t decoded
);

  // accept when empty or draining this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      decoded <= next;
    end
  end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  var logic               clk,
  input  var logic               reset,
  input  var logic               in_valid,
  output var logic               in_ready,
  input  var pipe_pkg::fetch_t   fetch,
  output var logic               out_valid,
  input  var logic               out_ready,
  output var pipe_pkg::decoded_t decoded
);

  pipe_pkg::decoded_t next_record;

  decode_logic u_decode_logic (
    .fetch (fetch),
    .next  (next_record)
  );

  stage_register u_stage_register (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .next      (next_record),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .decoded   (decoded)
  );

endmodule

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ns

module tb_decode_stage;

  localparam int period = 100;
  localparam int max_vectors = 64;

  logic clk;
  logic reset;
  logic in_valid;
  logic in_ready;
  pipe_pkg::fetch_t fetch;
  logic out_valid;
  logic out_ready;
  pipe_pkg::decoded_t decoded;

  pipe_pkg::fetch_t vec_fetch [max_vectors];
  pipe_pkg::decoded_t vec_expect [max_vectors];
  int vector_count;
  bit loaded;

  pipe_pkg::decoded_t expect_queue [$];
  int sent_cycle_queue [$];
  bit strict_timing;
  integer seed;

  bit hold_prev;
  pipe_pkg::decoded_t held;

  decode_stage uut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .fetch     (fetch),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .decoded   (decoded)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is %h, expected %h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic load_vectors();
    integer fd;
    integer code;
    string line;
    logic [31:0] f [11];
    fd = $fopen("testbench/decode_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file testbench/decode_input.txt");
      $display("Simulation FAILED");
      $fatal(1);
    end
    vector_count = 0;
    while (!$feof(fd) && vector_count < max_vectors) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 0 && line[0] != "#") begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                       f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        if (code == 11) begin
          vec_fetch[vector_count].instr = f[0];
          vec_fetch[vector_count].pc = f[1];
          vec_expect[vector_count].op = isa_pkg::op_e'(f[2][5:0]);
          vec_expect[vector_count].uses_imm = f[3][0];
          vec_expect[vector_count].rd = f[4][4:0];
          vec_expect[vector_count].rs1 = f[5][4:0];
          vec_expect[vector_count].rs2 = f[6][4:0];
          vec_expect[vector_count].immediate = f[7];
          vec_expect[vector_count].pc = f[1];
          vec_expect[vector_count].next_pc = f[8];
          vec_expect[vector_count].compressed = f[9][0];
          vec_expect[vector_count].illegal = f[10][0];
          vector_count++;
        end
      end
    end
    $fclose(fd);
    if (vector_count == 0) begin
      $display("the vector file holds no usable lines");
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // one pass over all vectors with optional random gaps and stalls
  task automatic send_all(input bit random_mode);
    int idx;
    idx = 0;
    while (idx < vector_count) begin
      @(posedge clk);
      if (strict_timing && in_valid) check_value("in_ready", in_ready, 1'b1);
      if (in_valid && in_ready) begin
        expect_queue.push_back(vec_expect[idx]);
        sent_cycle_queue.push_back($time / period);
        idx++;
      end
      if (random_mode) out_ready <= ($random(seed) & 1) != 0;
      else out_ready <= 1'b1;
      if (idx >= vector_count) begin
        in_valid <= 1'b0;
      end else if (!(in_valid && !in_ready)) begin
        fetch <= vec_fetch[idx];
        if (random_mode) in_valid <= ($random(seed) & 3) != 0;
        else in_valid <= 1'b1;
      end
    end
  endtask

  // output side checker for every transfer and the hold rule
  initial begin
    pipe_pkg::decoded_t exp_rec;
    int sent_cycle;
    hold_prev = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset) begin
        if (hold_prev) begin
          check_value("out_valid", out_valid, 1'b1);
          check_value("decoded", decoded, held);
        end
        if (out_valid && !out_ready) check_value("in_ready", in_ready, 1'b0);
        if (out_valid && out_ready) begin
          if (expect_queue.size() == 0) begin
            $display("a record came out that was never sent");
            $display("Simulation FAILED");
            $fatal(1);
          end
          exp_rec = expect_queue.pop_front();
          sent_cycle = sent_cycle_queue.pop_front();
          check_value("op", decoded.op, exp_rec.op);
          check_value("uses_imm", decoded.uses_imm, exp_rec.uses_imm);
          check_value("rd", decoded.rd, exp_rec.rd);
          check_value("rs1", decoded.rs1, exp_rec.rs1);
          check_value("rs2", decoded.rs2, exp_rec.rs2);
          check_value("immediate", decoded.immediate, exp_rec.immediate);
          check_value("pc", decoded.pc, exp_rec.pc);
          check_value("next_pc", decoded.next_pc, exp_rec.next_pc);
          check_value("compressed", decoded.compressed, exp_rec.compressed);
          check_value("illegal", decoded.illegal, exp_rec.illegal);
          if (strict_timing) check_value("latency", $time / period - sent_cycle, 1);
        end
        hold_prev = out_valid && !out_ready;
        held = decoded;
      end
    end
  end

  initial begin
    wait (loaded);
    #((16 + vector_count * 40) * period);
    $display("the run timed out before all records came out");
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial begin
    seed = 32'h885b3596;
    strict_timing = 1'b0;
    loaded = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    out_ready = 1'b0;
    fetch = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value("out_valid", out_valid, 1'b0);
    check_value("in_ready", in_ready, 1'b1);

    // full rate first, then random gaps and stalls
    strict_timing = 1'b1;
    send_all(1'b0);
    repeat (2) @(posedge clk);
    strict_timing = 1'b0;
    send_all(1'b1);
    out_ready <= 1'b1;
    while (expect_queue.size() != 0 || out_valid) @(posedge clk);
    @(posedge clk);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/rv32i_decoder.sv
source/rvc_decoder.sv
source/immediate_gen.sv
source/decode_logic.sv
source/stage_register.sv
source/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== testbench/decode_input.txt ====
# instr pc op uses_imm rd rs1 rs2 immediate next_pc compressed illegal, all hex
# op is the op_e value: lui 1, jal 3, lw d, sw 12, add 13, sra 1a, ecall 1d
00500093 00001000 13 1 01 00 05 00000005 00001004 0 0
ffc12283 00001004 0d 1 05 02 1c fffffffc 00001008 0 0
00612423 00001008 12 1 00 02 06 00000008 0000100c 0 0
00208863 0000100c 05 0 00 01 02 00000010 00001010 0 0
123451b7 00001010 01 1 03 08 03 12345000 00001014 0 0
00001217 00001014 02 1 04 00 00 00001000 00001018 0 0
008000ef 00001018 03 1 01 00 08 00000008 0000101c 0 0
00008067 0000101c 04 1 00 01 00 00000000 00001020 0 0
407302b3 00001020 14 0 05 06 07 00000000 00001024 0 0
4034d413 00001024 1a 1 08 09 03 00000403 00001028 0 0
00000073 00001028 1d 0 00 00 00 00000000 0000102c 0 0
00100073 0000102c 1e 0 00 00 01 00000000 00001030 0 0
0000007f 00001030 00 0 00 00 00 00000000 00001034 0 1
02208033 00001034 00 0 00 01 02 00000000 00001038 0 1
00000000 00002000 00 1 08 02 00 00000000 00002002 1 1
00000004 00002002 00 1 09 02 00 00000000 00002004 1 1
00000800 00002004 13 1 08 02 00 00000010 00002006 1 0
0000557d 00002006 13 1 0a 00 00 ffffffff 00002008 1 0
0000058d 00002008 13 1 0b 0b 00 00000003 0000200a 1 0
00004144 0000200a 0d 1 09 0a 00 00000004 0000200c 1 0
0000a801 0000200c 03 1 00 00 00 00000010 0000200e 1 0
0000c009 0000200e 05 0 00 08 00 00000002 00002010 1 0
00004092 00002010 0d 1 01 02 00 00000004 00002012 1 0
00008636 00002012 13 0 0c 00 0d 00000000 00002014 1 0
00009282 00002014 04 1 01 05 00 00000000 00002016 1 0
0000c622 00002016 12 1 00 02 08 0000000c 00002018 1 0
00006785 00002018 01 1 0f 00 00 00001000 0000201a 1 0
